/* Bender.yml */
package:
  name: readCache

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - cachePkg.sv
      - cacheCtrl.sv
      - refillCollector.sv
      - tagStore.sv
      - dataStore.sv
      - readCache.sv
  - target: test
    include_dirs:
      - .
    files:
      - tbMemModel.sv
      - tb_readCache.sv

/* cacheCtrl.sv */
`include "cache_macros.svh"

module cacheCtrl import cachePkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     reqValid_i,
  input  addr_t    reqAddr_i,
  input  logic     hit_i,
  input  logic     memRdReady_i,
  input  logic     lineDone_i,
  output logic     reqReady_o,
  output logic     rspValid_o,
  output logic     memRdValid_o,
  output addr_t    memRdAddr_o,
  output index_t   lookupIndex_o,
  output tag_t     lookupTag_o,
  output wordSel_t wordSel_o,
  output logic     collectEn_o,
  output logic     fillEn_o
);

  // low address bits that pick a byte inside a word
  localparam int BYTE_W = $clog2(`WORD_W / 8);

  ctrlState_t state;
  ctrlState_t nextState;
  addr_t      reqLatch;
  logic       accept;

  // requester handshake
  // ready in IDLE or in LOOKUP once the current request has hit
  assign reqReady_o = (state == IDLE) || ((state == LOOKUP) && hit_i);
  assign accept     = reqValid_i && reqReady_o;

  // one-shot response while the lookup hits
  assign rspValid_o = (state == LOOKUP) && hit_i;

  // strobes for the memory port and the stores
  assign memRdValid_o = (state == MISS);
  assign collectEn_o  = (state == REFILL);
  assign fillEn_o     = (state == UPDATE);

  // request latch reloaded on every accept
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      reqLatch <= '0;
    end else if (accept) begin
      reqLatch <= reqAddr_i;
    end
  end

  // address fields from the latched request
  assign lookupIndex_o = reqLatch[`OFFSET_W +: `INDEX_W];
  assign lookupTag_o   = reqLatch[`OFFSET_W + `INDEX_W +: `TAG_W];
  assign wordSel_o     = reqLatch[BYTE_W +: $bits(wordSel_t)];

  // line aligned burst address
  assign memRdAddr_o = {lookupTag_o, lookupIndex_o, {`OFFSET_W{1'b0}}};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= IDLE;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    nextState = state;
    case (state)
      IDLE: begin
        if (accept) begin
          nextState = LOOKUP;
        end
      end
      LOOKUP: begin
        // hit with a new accept stays while a plain hit drains to idle
        if (!hit_i) begin
          nextState = MISS;
        end else if (!accept) begin
          nextState = IDLE;
        end
      end
      MISS: begin
        if (memRdReady_i) begin
          nextState = REFILL;
        end
      end
      REFILL: begin
        if (lineDone_i) begin
          nextState = UPDATE;
        end
      end
      UPDATE: begin
        // line written on this edge before the replayed lookup
        nextState = LOOKUP;
      end
      default: begin
        nextState = IDLE;
      end
    endcase
  end

  // state register only ever holds one of the five encodings
  assert property (@(posedge clk) disable iff (!rst_n)
    state inside {IDLE, LOOKUP, MISS, REFILL, UPDATE});

  // burst request held with a stable address until the memory takes it
  assert property (@(posedge clk) disable iff (!rst_n)
    memRdValid_o && !memRdReady_i |=> memRdValid_o && $stable(memRdAddr_o));

endmodule

/* cachePkg.sv */
`include "cache_macros.svh"

package cachePkg;

  // request and memory addresses
  typedef logic [`ADDR_W-1:0] addr_t;

  // address fields
  typedef logic [`TAG_W-1:0] tag_t;
  typedef logic [`INDEX_W-1:0] index_t;

  // word position inside a line, address bits 4:3
  typedef logic [$clog2(`BEATS)-1:0] wordSel_t;

  // data path
  typedef logic [`WORD_W-1:0] word_t;
  typedef logic [`LINE_W-1:0] line_t;

  // way number
  typedef logic [$clog2(`WAYS)-1:0] way_t;

  // controller states
  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    MISS,
    REFILL,
    UPDATE
  } ctrlState_t;

endpackage

/* cache_macros.svh */
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// byte address as seen by the requester and the memory port
`define ADDR_W 32

// address split into tag, set index and byte offset in the line
`define TAG_W 21
`define INDEX_W 6
`define OFFSET_W 5

// one data word, also one memory beat
`define WORD_W 64

// beats per refill burst
`define BEATS 4

// full line, word 0 in the low bits
`define LINE_W 256

// associativity
`define WAYS 2

`endif

/* dataStore.sv */
`include "cache_macros.svh"

module dataStore import cachePkg::*; (
  input  logic     clk,
  input  index_t   index_i,
  input  wordSel_t wordSel_i,
  input  logic     fillEn_i,
  input  way_t     fillWay_i,
  input  line_t    lineData_i,
  input  way_t     hitWay_i,
  output word_t    rdData_o
);

  localparam int SETS = 2 ** `INDEX_W;

  // line storage, one array per way
  line_t lineArr [`WAYS][SETS];

  // line of the hit way in the addressed set
  line_t hitLine;

  // whole line written in one go
  always_ff @(posedge clk) begin
    if (fillEn_i) begin
      lineArr[fillWay_i][index_i] <= lineData_i;
    end
  end

  // combinational read of the latched set
  assign hitLine = lineArr[hitWay_i][index_i];

  // word pick, word 0 sits in the low bits
  assign rdData_o = hitLine[wordSel_i * `WORD_W +: `WORD_W];

endmodule

/* filelist.f */
+incdir+.
cachePkg.sv
cacheCtrl.sv
refillCollector.sv
tagStore.sv
dataStore.sv
readCache.sv
tbMemModel.sv
tb_readCache.sv

/* readCache.sv */
module readCache import cachePkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  // requester side
  input  logic  reqValid_i,
  input  addr_t reqAddr_i,
  output logic  reqReady_o,
  output logic  rspValid_o,
  output word_t rspData_o,
  // burst read memory side
  output logic  memRdValid_o,
  output addr_t memRdAddr_o,
  input  logic  memRdReady_i,
  input  word_t memData_i,
  input  logic  memDataValid_i,
  input  logic  memRdLast_i
);

  // lookup fields from the controller latch
  index_t   lookupIndex;
  tag_t     lookupTag;
  wordSel_t wordSel;

  // tag compare results
  logic hit;
  way_t hitWay;
  way_t victimWay;

  // refill path
  logic  collectEn;
  logic  lineDone;
  line_t lineData;
  logic  fillEn;

  cacheCtrl u_cacheCtrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .reqValid_i    (reqValid_i),
    .reqAddr_i     (reqAddr_i),
    .hit_i         (hit),
    .memRdReady_i  (memRdReady_i),
    .lineDone_i    (lineDone),
    .reqReady_o    (reqReady_o),
    .rspValid_o    (rspValid_o),
    .memRdValid_o  (memRdValid_o),
    .memRdAddr_o   (memRdAddr_o),
    .lookupIndex_o (lookupIndex),
    .lookupTag_o   (lookupTag),
    .wordSel_o     (wordSel),
    .collectEn_o   (collectEn),
    .fillEn_o      (fillEn)
  );

  refillCollector u_refillCollector (
    .clk         (clk),
    .rst_n       (rst_n),
    .collectEn_i (collectEn),
    .beatValid_i (memDataValid_i),
    .beatLast_i  (memRdLast_i),
    .beatData_i  (memData_i),
    .lineData_o  (lineData),
    .lineDone_o  (lineDone)
  );

  // the response strobe marks a used line for lru
  tagStore u_tagStore (
    .clk           (clk),
    .rst_n         (rst_n),
    .lookupIndex_i (lookupIndex),
    .lookupTag_i   (lookupTag),
    .touchEn_i     (rspValid_o),
    .fillEn_i      (fillEn),
    .hit_o         (hit),
    .hitWay_o      (hitWay),
    .victimWay_o   (victimWay)
  );

  // refill goes into the victim way named by the tag store
  dataStore u_dataStore (
    .clk        (clk),
    .index_i    (lookupIndex),
    .wordSel_i  (wordSel),
    .fillEn_i   (fillEn),
    .fillWay_i  (victimWay),
    .lineData_i (lineData),
    .hitWay_i   (hitWay),
    .rdData_o   (rspData_o)
  );

endmodule

/* refillCollector.sv */
`include "cache_macros.svh"

module refillCollector import cachePkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  collectEn_i,
  input  logic  beatValid_i,
  input  logic  beatLast_i,
  input  word_t beatData_i,
  output line_t lineData_o,
  output logic  lineDone_o
);

  // beat position in the line, wraps after the last one
  wordSel_t beatCnt;
  line_t    lineBuf;
  logic     beatTake;

  // beats only count while the controller is refilling
  assign beatTake = collectEn_i && beatValid_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beatCnt <= '0;
    end else if (beatTake) begin
      beatCnt <= beatCnt + 1'b1;
    end
  end

  // each beat lands in its own word slot
  // beats come in address order so slot = count
  always_ff @(posedge clk) begin
    if (beatTake) begin
      lineBuf[beatCnt * `WORD_W +: `WORD_W] <= beatData_i;
    end
  end

  assign lineData_o = lineBuf;

  // buffer is full on the edge that takes this beat
  assign lineDone_o = beatTake && beatLast_i;

  // last flag only and always on the fourth beat
  assert property (@(posedge clk) disable iff (!rst_n)
    beatTake |-> (beatLast_i == (beatCnt == wordSel_t'(`BEATS - 1))));

endmodule

/* tagStore.sv */
`include "cache_macros.svh"

module tagStore import cachePkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  input  index_t lookupIndex_i,
  input  tag_t   lookupTag_i,
  input  logic   touchEn_i,
  input  logic   fillEn_i,
  output logic   hit_o,
  output way_t   hitWay_o,
  output way_t   victimWay_o
);

  localparam int SETS = 2 ** `INDEX_W;

  // tags per way and set
  tag_t tagArr [`WAYS][SETS];

  // valid bits, one vector per way
  logic [`WAYS-1:0][SETS-1:0] validBits;

  // lru bit per set, names the way to evict next
  logic [SETS-1:0] lruBits;

  logic [`WAYS-1:0] wayHit;

  // compare both ways against the latched tag
  always_comb begin
    for (int w = 0; w < `WAYS; w++) begin
      wayHit[w] = validBits[w][lookupIndex_i] &&
                  (tagArr[w][lookupIndex_i] == lookupTag_i);
    end
  end

  assign hit_o       = |wayHit;
  // two ways, so way 1 hitting names the hit way
  assign hitWay_o    = way_t'(wayHit[1]);
  assign victimWay_o = way_t'(lruBits[lookupIndex_i]);

  // tag written into the victim way on the fill edge
  always_ff @(posedge clk) begin
    if (fillEn_i) begin
      tagArr[victimWay_o][lookupIndex_i] <= lookupTag_i;
    end
  end

  // valid and lru state
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validBits <= '0;
      lruBits   <= '0;
    end else if (fillEn_i) begin
      validBits[victimWay_o][lookupIndex_i] <= 1'b1;
      // freshly filled way is the most recent one
      lruBits[lookupIndex_i] <= ~victimWay_o;
    end else if (touchEn_i) begin
      // point away from the way just read
      lruBits[lookupIndex_i] <= ~hitWay_o;
    end
  end

  // a set never holds the same tag in both ways
  // relies on fill only running after a lookup miss
  assert property (@(posedge clk) disable iff (!rst_n)
    !(wayHit[0] && wayHit[1]));

endmodule

/* tbMemModel.sv */
`include "cache_macros.svh"

module tbMemModel import cachePkg::*; (
  input  logic       clk,
  input  logic       memRdValid_i,
  input  addr_t      memRdAddr_i,
  input  logic [3:0] maxGap_i,
  output logic       memRdReady_o,
  output word_t      memData_o,
  output logic       memDataValid_o,
  output logic       memRdLast_o
);

  // beat n of a line carries the word address on top and its inverse below
  function automatic word_t beatWord(input addr_t lineAddr, input int beat);
    addr_t wordAddr;
    wordAddr = lineAddr + addr_t'(8 * beat);
    return {wordAddr, ~wordAddr};
  endfunction

  // one burst at a time with everything moving on the falling edge
  initial begin
    addr_t lineAddr;
    int    gap;
    void'($urandom(32'h2f37));
    memRdReady_o   = 1'b0;
    memData_o      = '0;
    memDataValid_o = 1'b0;
    memRdLast_o    = 1'b0;
    forever begin
      @(negedge clk);
      if (memRdValid_i) begin
        lineAddr = memRdAddr_i;
        // random delay before taking the request
        gap = $urandom_range(maxGap_i, 0);
        repeat (gap) @(negedge clk);
        memRdReady_o = 1'b1;
        @(negedge clk);
        memRdReady_o = 1'b0;
        for (int b = 0; b < `BEATS; b++) begin
          // idle gap ahead of each beat
          gap = $urandom_range(maxGap_i, 0);
          repeat (gap) @(negedge clk);
          memDataValid_o = 1'b1;
          memData_o      = beatWord(lineAddr, b);
          memRdLast_o    = (b == `BEATS - 1);
          @(negedge clk);
          memDataValid_o = 1'b0;
          memRdLast_o    = 1'b0;
        end
      end
    end
  end

endmodule

/* tb_readCache.sv */
module tb_readCache import cachePkg::*; ();

  localparam int REQ_LIMIT  = 200;
  localparam int IDLE_LIMIT = 400;

  logic       clk;
  logic       rst_n;
  logic       reqValid;
  addr_t      reqAddr;
  logic       reqReady;
  logic       rspValid;
  word_t      rspData;
  logic       memRdValid;
  addr_t      memRdAddr;
  logic       memRdReady;
  word_t      memData;
  logic       memDataValid;
  logic       memRdLast;
  logic [3:0] maxGap;

  // what the current access is expected to do
  logic  expHit;
  logic  expMiss;
  logic  noMemPhase;
  string testName;

  // last accepted address and bursts since then
  addr_t lastAcc;
  int    burstCnt;
  word_t expWord;
  addr_t expLine;

  readCache u_readCache (
    .clk            (clk),
    .rst_n          (rst_n),
    .reqValid_i     (reqValid),
    .reqAddr_i      (reqAddr),
    .reqReady_o     (reqReady),
    .rspValid_o     (rspValid),
    .rspData_o      (rspData),
    .memRdValid_o   (memRdValid),
    .memRdAddr_o    (memRdAddr),
    .memRdReady_i   (memRdReady),
    .memData_i      (memData),
    .memDataValid_i (memDataValid),
    .memRdLast_i    (memRdLast)
  );

  tbMemModel u_tbMemModel (
    .clk            (clk),
    .memRdValid_i   (memRdValid),
    .memRdAddr_i    (memRdAddr),
    .maxGap_i       (maxGap),
    .memRdReady_o   (memRdReady),
    .memData_o      (memData),
    .memDataValid_o (memDataValid),
    .memRdLast_o    (memRdLast)
  );

  // memory word carries the 8-byte aligned address on top and its inverse below
  assign expLine = {lastAcc[31:5], 5'b0};
  assign expWord = {{lastAcc[31:3], 3'b0}, ~{lastAcc[31:3], 3'b0}};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lastAcc  <= '0;
      burstCnt <= 0;
    end else if (reqValid && reqReady) begin
      lastAcc  <= reqAddr;
      burstCnt <= 0;
    end else if (memRdValid && memRdReady) begin
      burstCnt <= burstCnt + 1;
    end
  end

  task automatic stopRun(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic reportValue(input string check, input logic [63:0] exp, input logic [63:0] act);
    stopRun($sformatf("FAIL %s %s: expected %h, actual %h", testName, check, exp, act));
  endtask

  // reset behaviour
  assert property (@(posedge clk) !rst_n |-> !rspValid && !memRdValid)
    else stopRun($sformatf("%s: response or burst request active in reset", testName));
  assert property (@(posedge clk) $rose(rst_n) |-> reqReady && !rspValid && !memRdValid)
    else stopRun($sformatf("%s: cache not idle and ready after reset", testName));

  // every response carries the memory word of its accepted address
  assert property (@(posedge clk) disable iff (!rst_n) rspValid |-> rspData == expWord)
    else reportValue("response data", $sampled(expWord), $sampled(rspData));

  // bursts fetch the line of the pending request
  assert property (@(posedge clk) disable iff (!rst_n) memRdValid |-> memRdAddr == expLine)
    else reportValue("burst address", 64'($sampled(expLine)), 64'($sampled(memRdAddr)));
  assert property (@(posedge clk) disable iff (!rst_n) burstCnt <= 1)
    else stopRun($sformatf("%s: more than one burst for one request", testName));

  // hit answers one cycle after the accept
  assert property (@(posedge clk) disable iff (!rst_n)
    reqValid && reqReady && expHit |=> rspValid && !memRdValid)
    else stopRun($sformatf("%s: expected hit did not respond one cycle after accept", testName));
  // miss spends one cycle in lookup and then requests the burst
  assert property (@(posedge clk) disable iff (!rst_n)
    reqValid && reqReady && expMiss |=> !rspValid ##1 memRdValid)
    else stopRun($sformatf("%s: expected miss raised no burst request", testName));
  assert property (@(posedge clk) disable iff (!rst_n) noMemPhase |-> !memRdValid)
    else stopRun($sformatf("%s: burst request while only hits expected", testName));

  // burst held steady under back-pressure
  assert property (@(posedge clk) disable iff (!rst_n)
    memRdValid && !memRdReady |=> memRdValid && $stable(memRdAddr))
    else stopRun($sformatf("%s: burst request dropped or moved before handshake", testName));

  // update cycle and then the replayed lookup answers
  assert property (@(posedge clk) disable iff (!rst_n) memDataValid && memRdLast |-> ##2 rspValid)
    else stopRun($sformatf("%s: no response two cycles after the last beat", testName));

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // called on a falling edge and returns on the falling edge after the accept
  task automatic access(input addr_t addr, input logic hitExp, input logic missExp);
    int cycles;
    reqValid = 1'b1;
    reqAddr  = addr;
    expHit   = hitExp;
    expMiss  = missExp;
    cycles   = 0;
    while (!reqReady) begin
      @(negedge clk);
      cycles++;
      if (cycles > REQ_LIMIT) begin
        stopRun($sformatf("%s: request %h never accepted", testName, addr));
      end
    end
    @(negedge clk);
    reqValid = 1'b0;
    expHit   = 1'b0;
    expMiss  = 1'b0;
  endtask

  // idle means ready with no response still going out
  task automatic waitIdle();
    int cycles;
    cycles = 0;
    while (!(reqReady && !rspValid)) begin
      @(negedge clk);
      cycles++;
      if (cycles > IDLE_LIMIT) begin
        stopRun($sformatf("%s: cache did not return to idle", testName));
      end
    end
  endtask

  initial begin
    addr_t lineA;
    addr_t lineB;
    addr_t lineC;
    addr_t addr;
    // three lines in set 2
    lineA      = 32'h0000_1040;
    lineB      = 32'h0000_1840;
    lineC      = 32'h0000_2040;
    testName   = "reset";
    rst_n      = 1'b1;
    reqValid   = 1'b0;
    reqAddr    = '0;
    expHit     = 1'b0;
    expMiss    = 1'b0;
    noMemPhase = 1'b0;
    maxGap     = 4'd2;
    #1 rst_n = 1'b0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    repeat (2) @(negedge clk);

    testName = "miss_data";
    access(32'h0000_0318, 1'b0, 1'b1);
    waitIdle();

    // all four words back to back
    testName   = "hit_timing";
    noMemPhase = 1'b1;
    for (int w = 0; w < 4; w++) begin
      access(32'h0000_0300 + addr_t'(8 * w), 1'b1, 1'b0);
    end
    waitIdle();
    noMemPhase = 1'b0;

    // A, B, A, C evicts B
    testName = "lru";
    access(lineA, 1'b0, 1'b1);
    waitIdle();
    access(lineB, 1'b0, 1'b1);
    waitIdle();
    access(lineA + 32'h8, 1'b1, 1'b0);
    waitIdle();
    access(lineC + 32'h10, 1'b0, 1'b1);
    waitIdle();
    noMemPhase = 1'b1;
    access(lineA + 32'h18, 1'b1, 1'b0);
    waitIdle();
    noMemPhase = 1'b0;
    access(lineB + 32'h8, 1'b0, 1'b1);
    waitIdle();

    // fresh sets with slow memory
    testName = "backpressure";
    maxGap   = 4'd15;
    for (int i = 0; i < 4; i++) begin
      addr = {21'(i * 37 + 5), 6'(40 + i), 2'(i), 3'b000};
      access(addr, 1'b0, 1'b1);
      waitIdle();
      access(addr, 1'b1, 1'b0);
      waitIdle();
    end

    repeat (4) @(negedge clk);
    $display("TEST OK");
    $finish;
  end

endmodule
